// File: Makefile
TOP = csr_file_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

# assertions keep running after a failure so the testbench can report it
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: filelist.f
verilog/csr_pkg.sv
verilog/csr_op_decode.sv
verilog/csr_addr_decode.sv
verilog/csr_read_mux.sv
verilog/csr_machine_regs.sv
verilog/csr_trap_ctrl.sv
verilog/mvu_cfg_port.sv
verilog/csr_file.sv
tb/csr_file_asserts.sv
tb/csr_file_tb.sv

// File: tb/csr_file_asserts.sv
`timescale 1ns/100ps
module csr_file_asserts #(
    parameter int unsigned hart_id = 0
) (
    input logic                           clk,
    input logic                           mtvec_rst_load_q,
    input logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
    input logic [csr_pkg::CSR_OP_W-1:0]   csr_op_i,
    input logic [csr_pkg::XLEN-1:0]       csr_rdata_o,
    input logic                           csr_illegal_o,
    input logic                           irq_i,
    input logic                           time_irq_i,
    input logic                           ipi_i,
    input logic                           mvu_irq_i,
    input logic [csr_pkg::XLEN-1:0]       boot_addr_i,
    input logic [csr_pkg::XLEN-1:0]       pc_i,
    input logic [csr_pkg::XLEN-1:0]       cause_i,
    input logic                           cycle_en_i,
    input logic                           irq_evt_valid_o,
    input logic [csr_pkg::XLEN-1:0]       irq_evt_addr_o,
    input logic [csr_pkg::XLEN-1:0]       mvu_paddr_o,
    input logic [csr_pkg::XLEN-1:0]       mvu_pwdata_o,
    input logic                           mvu_psel_o,
    input logic                           mvu_penable_o,
    input logic                           mvu_pwrite_o
);
    import csr_pkg::*;

    // mstatus enable bits
    localparam int MST_MIE  = 3;
    localparam int MST_MPIE = 7;
    // a write keeps everything except sd, xs, fs, upie and uie
    localparam logic [XLEN-1:0] MSTATUS_KEEP = ~32'h8001_E011;

    int              fail_cnt = 0;
    // shadow copies of the architectural state
    logic [XLEN-1:0] sh_mstatus;
    logic [XLEN-1:0] sh_mie;
    logic [XLEN-1:0] sh_mtvec;
    logic [XLEN-1:0] sh_mepc;
    logic [XLEN-1:0] sh_mcause;
    logic [XLEN-1:0] sh_mtval;
    logic            sh_mip_mvu;
    logic            sh_mip_ext;
    logic            sh_mip_timer;
    logic            sh_mip_soft;
    logic [63:0]     sh_mcycle;
    // expected bus write one cycle after an accelerator access
    logic            bus_v;
    logic [XLEN-1:0] bus_addr;
    logic [XLEN-1:0] bus_data;
    logic            rmw_op;
    logic            is_mret;
    logic            trap;
    logic            tracked;
    logic            mapped;
    logic [XLEN-1:0] exp_rd;
    logic [XLEN-1:0] new_val;

    assign rmw_op  = csr_op_i inside {CSR_OP_RW, CSR_OP_SET, CSR_OP_CLEAR};
    assign is_mret = csr_op_i == CSR_OP_MRET;
    // mvu pending, enabled, and global enable
    assign trap    = sh_mstatus[MST_MIE] & sh_mie[IRQ_MVU] & sh_mip_mvu;
    assign mapped  = (csr_addr_i >= MVU_CSR_BASE) || (csr_addr_i inside {CSR_MSTATUS,
                     CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP,
                     CSR_MCYCLE, CSR_MCYCLEH, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
                     CSR_MHARTID});

    //======================================================================
    // expected read word and merged write value
    //======================================================================
    always_comb begin
        tracked = 1'b1;
        case (csr_addr_i)
            CSR_MSTATUS: exp_rd = sh_mstatus;
            CSR_MIE:     exp_rd = sh_mie;
            CSR_MTVEC:   exp_rd = sh_mtvec;
            CSR_MEPC:    exp_rd = sh_mepc;
            CSR_MCAUSE:  exp_rd = sh_mcause;
            CSR_MTVAL:   exp_rd = sh_mtval;
            CSR_MCYCLE:  exp_rd = sh_mcycle[31:0];
            CSR_MCYCLEH: exp_rd = sh_mcycle[63:32];
            CSR_MHARTID: exp_rd = hart_id;
            // sticky mvu bit plus the three sampled lines
            CSR_MIP:     exp_rd = {15'd0, sh_mip_mvu, 4'd0, sh_mip_ext, 3'd0, sh_mip_timer,
                                   3'd0, sh_mip_soft, 3'd0};
            default: begin
                exp_rd  = '0;
                tracked = 1'b0;
            end
        endcase
        case (csr_op_i)
            CSR_OP_SET:   new_val = exp_rd | csr_wdata_i;
            CSR_OP_CLEAR: new_val = exp_rd & ~csr_wdata_i;
            default:      new_val = csr_wdata_i;
        endcase
    end

    //======================================================================
    // shadow state
    //======================================================================
    always_ff @(posedge clk) begin
        if (mtvec_rst_load_q) begin
            sh_mstatus   <= '0;
            sh_mie       <= '0;
            sh_mtvec     <= boot_addr_i;
            sh_mepc      <= '0;
            sh_mcause    <= '0;
            sh_mtval     <= '0;
            sh_mip_mvu   <= 1'b0;
            sh_mip_ext   <= 1'b0;
            sh_mip_timer <= 1'b0;
            sh_mip_soft  <= 1'b0;
            sh_mcycle    <= '0;
            bus_v        <= 1'b0;
        end else begin
            sh_mcycle <= sh_mcycle + 64'(cycle_en_i);
            bus_v     <= rmw_op && (csr_addr_i >= MVU_CSR_BASE);
            bus_addr  <= {20'd0, csr_addr_i};
            bus_data  <= new_val;
            // level lines show up one edge later
            sh_mip_ext   <= irq_i;
            sh_mip_timer <= time_irq_i;
            sh_mip_soft  <= ipi_i;
            // sticky until software writes mip
            if (rmw_op && csr_addr_i == CSR_MIP) begin
                sh_mip_mvu <= new_val[IRQ_MVU];
            end else if (mvu_irq_i) begin
                sh_mip_mvu <= 1'b1;
            end
            if (rmw_op) begin
                case (csr_addr_i)
                    CSR_MSTATUS: sh_mstatus <= new_val & MSTATUS_KEEP;
                    CSR_MIE:     sh_mie     <= new_val & MIP_MASK;
                    CSR_MTVEC:   sh_mtvec   <= new_val;
                    CSR_MEPC:    sh_mepc    <= new_val & ~32'd1;
                    CSR_MTVAL:   sh_mtval   <= new_val;
                    default: ;
                endcase
            end
            // trap entry saves state and masks further interrupts
            if (trap) begin
                sh_mstatus[MST_MPIE] <= sh_mstatus[MST_MIE];
                sh_mstatus[MST_MIE]  <= 1'b0;
                sh_mepc              <= pc_i;
                sh_mcause            <= {1'b1, 26'd0, cause_i[4:0]};
            end
            if (is_mret) begin
                sh_mstatus[MST_MIE]  <= sh_mstatus[MST_MPIE];
                sh_mstatus[MST_MPIE] <= 1'b1;
            end
        end
    end

    //======================================================================
    // checks
    //======================================================================
    a_rdata: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        rmw_op && tracked |-> csr_rdata_o == exp_rd)
        else begin
            fail_cnt++;
            $error("read data differs from the expected csr value");
        end

    a_illegal: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        csr_illegal_o == (rmw_op && !mapped))
        else begin
            fail_cnt++;
            $error("illegal flag wrong for this access");
        end

    a_evt: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        irq_evt_valid_o == (trap || is_mret))
        else begin
            fail_cnt++;
            $error("event valid wrong");
        end

    // mret goes back to mepc, a trap goes to the vector
    a_evt_addr: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        irq_evt_valid_o |-> irq_evt_addr_o == (is_mret ? sh_mepc : sh_mtvec))
        else begin
            fail_cnt++;
            $error("event target address wrong");
        end

    a_bus_strobe: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        {mvu_psel_o, mvu_penable_o, mvu_pwrite_o} == {3{bus_v}})
        else begin
            fail_cnt++;
            $error("accelerator bus strobes wrong");
        end

    a_bus_data: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        bus_v |-> mvu_paddr_o == bus_addr && mvu_pwdata_o == bus_data)
        else begin
            fail_cnt++;
            $error("accelerator bus address or data wrong");
        end

endmodule

bind csr_file csr_file_asserts #(.hart_id(hart_id)) u_asserts (.*);

// File: tb/csr_file_tb.sv
`timescale 1ns/100ps
module csr_file_tb;
    import csr_pkg::*;

    // about 50 cycles of stimulus, plenty of margin
    localparam int MAX_CYCLES = 400;

    logic                  clk;
    logic                  mtvec_rst_load_q;
    logic [CSR_ADDR_W-1:0] csr_addr_i;
    logic [XLEN-1:0]       csr_wdata_i;
    logic [CSR_OP_W-1:0]   csr_op_i;
    logic [XLEN-1:0]       csr_rdata_o;
    logic                  csr_illegal_o;
    logic                  irq_i;
    logic                  time_irq_i;
    logic                  ipi_i;
    logic                  mvu_irq_i;
    logic [XLEN-1:0]       boot_addr_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       cause_i;
    logic                  cycle_en_i;
    logic                  irq_evt_valid_o;
    logic [XLEN-1:0]       irq_evt_addr_o;
    logic [XLEN-1:0]       mvu_paddr_o;
    logic [XLEN-1:0]       mvu_pwdata_o;
    logic                  mvu_psel_o;
    logic                  mvu_penable_o;
    logic                  mvu_pwrite_o;
    int                    seed = 32'hbe86;
    int                    cycle_cnt = 0;

    csr_file #(.hart_id(5)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one access per cycle, inputs change just after the edge
    task automatic access_csr(input logic [CSR_OP_W-1:0] op,
                              input logic [CSR_ADDR_W-1:0] addr,
                              input logic [XLEN-1:0] data);
        csr_op_i    <= op;
        csr_addr_i  <= addr;
        csr_wdata_i <= data;
        @(posedge clk);
    endtask

    // set with zero reads without changing anything
    task automatic read_csr(input logic [CSR_ADDR_W-1:0] addr);
        access_csr(CSR_OP_SET, addr, '0);
    endtask

    task automatic idle_cycles(input int n);
        csr_op_i <= CSR_OP_NONE;
        repeat (n) @(posedge clk);
    endtask

    //======================================================================
    // stimulus
    //======================================================================
    initial begin
        mtvec_rst_load_q <= 1'b1;
        csr_addr_i       <= '0;
        csr_wdata_i      <= '0;
        csr_op_i         <= CSR_OP_NONE;
        irq_i            <= 1'b0;
        time_irq_i       <= 1'b0;
        ipi_i            <= 1'b0;
        mvu_irq_i        <= 1'b0;
        boot_addr_i      <= 32'h0000_8000;
        pc_i             <= 32'h0000_4a6c;
        cause_i          <= 32'h0000_0ff3;
        cycle_en_i       <= 1'b0;
        repeat (2) @(posedge clk);
        mtvec_rst_load_q <= 1'b0;
        idle_cycles(1);

        // reset values
        read_csr(CSR_MTVEC);
        read_csr(CSR_MHARTID);
        read_csr(CSR_MSTATUS);

        // rw, set, clear on mtval, each read checks the previous result
        access_csr(CSR_OP_RW, CSR_MTVAL, $random(seed));
        access_csr(CSR_OP_SET, CSR_MTVAL, $random(seed));
        access_csr(CSR_OP_CLEAR, CSR_MTVAL, $random(seed));
        read_csr(CSR_MTVAL);
        // masked registers
        access_csr(CSR_OP_RW, CSR_MIE, $random(seed));
        read_csr(CSR_MIE);
        access_csr(CSR_OP_RW, CSR_MSTATUS, 32'hffff_ffff);
        read_csr(CSR_MSTATUS);

        // unmapped address, then mret which is never illegal
        access_csr(CSR_OP_RW, 12'h7c0, $random(seed));
        access_csr(CSR_OP_MRET, 12'h7c0, '0);
        idle_cycles(1);

        // accelerator bus write
        access_csr(CSR_OP_RW, 12'hf24, $random(seed));
        idle_cycles(2);

        //==================================================================
        // trap on the mvu line and return
        //==================================================================
        access_csr(CSR_OP_RW, CSR_MSTATUS, 32'h0000_0008);
        access_csr(CSR_OP_RW, CSR_MIE, 32'h0001_0000);
        idle_cycles(1);
        mvu_irq_i <= 1'b1;
        @(posedge clk);
        mvu_irq_i <= 1'b0;
        idle_cycles(3);
        read_csr(CSR_MEPC);
        read_csr(CSR_MCAUSE);
        read_csr(CSR_MSTATUS);
        // pending bit still held, level lines appear one read later
        ipi_i      <= 1'b1;
        time_irq_i <= 1'b1;
        irq_i      <= 1'b1;
        read_csr(CSR_MIP);
        read_csr(CSR_MIP);
        ipi_i      <= 1'b0;
        time_irq_i <= 1'b0;
        irq_i      <= 1'b0;
        // drop the sticky pending bit before returning
        access_csr(CSR_OP_CLEAR, CSR_MIP, 32'h0001_0000);
        access_csr(CSR_OP_MRET, '0, '0);
        idle_cycles(1);
        read_csr(CSR_MSTATUS);

        // cycle counter over ten enabled cycles
        read_csr(CSR_MCYCLE);
        cycle_en_i <= 1'b1;
        idle_cycles(10);
        cycle_en_i <= 1'b0;
        read_csr(CSR_MCYCLE);
        read_csr(CSR_MCYCLEH);
        idle_cycles(2);
        // checks of the last edge complete first
        @(negedge clk);

        if (DUT.u_asserts.fail_cnt == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "assertion checks failed");
        end
    end

    //======================================================================
    // failure watch and cycle limit
    //======================================================================
    always @(negedge clk) begin
        if (DUT.u_asserts.fail_cnt != 0) begin
            $display("mismatch at %0t: %0d assertion check(s) failed", $time,
                     DUT.u_asserts.fail_cnt);
            $display("TEST FAIL");
            $fatal(1, "stopped at first assertion failure");
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

endmodule

// File: verilog/csr_addr_decode.sv
`timescale 1ns/100ps
module csr_addr_decode (
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic                           csr_we_i,
    input  logic                           csr_re_i,
    output logic [csr_pkg::SEL_W-1:0]      sel_o,
    output logic                           illegal_o
);
    import csr_pkg::*;

    always_comb begin
        if (addr_i >= MVU_CSR_BASE) begin
            // whole upper range goes to the accelerator
            sel_o = SEL_MVU;
        end else begin
            case (addr_i)
                CSR_MSTATUS:   sel_o = SEL_MSTATUS;
                CSR_MISA:      sel_o = SEL_MISA;
                CSR_MIE:       sel_o = SEL_MIE;
                CSR_MTVEC:     sel_o = SEL_MTVEC;
                CSR_MEPC:      sel_o = SEL_MEPC;
                CSR_MCAUSE:    sel_o = SEL_MCAUSE;
                CSR_MTVAL:     sel_o = SEL_MTVAL;
                CSR_MIP:       sel_o = SEL_MIP;
                CSR_MCYCLE:    sel_o = SEL_MCYCLE;
                CSR_MCYCLEH:   sel_o = SEL_MCYCLEH;
                // identity regs, writes just fall through
                CSR_MVENDORID: sel_o = SEL_MVENDORID;
                CSR_MARCHID:   sel_o = SEL_MARCHID;
                CSR_MIMPID:    sel_o = SEL_MIMPID;
                CSR_MHARTID:   sel_o = SEL_MHARTID;
                default:       sel_o = SEL_NONE;
            endcase
        end
    end

    // unmapped address on a real access
    assign illegal_o = (csr_we_i | csr_re_i) & (sel_o == SEL_NONE);

endmodule

// File: verilog/csr_file.sv
`timescale 1ns/100ps
module csr_file #(
    parameter int unsigned hart_id = 0
) (
    input  logic                           clk,
    input  logic                           mtvec_rst_load_q,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
    input  logic [csr_pkg::CSR_OP_W-1:0]   csr_op_i,
    output logic [csr_pkg::XLEN-1:0]       csr_rdata_o,
    output logic                           csr_illegal_o,
    // interrupt lines
    input  logic                           irq_i,
    input  logic                           time_irq_i,
    input  logic                           ipi_i,
    input  logic                           mvu_irq_i,
    // core side
    input  logic [csr_pkg::XLEN-1:0]       boot_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       pc_i,
    input  logic [csr_pkg::XLEN-1:0]       cause_i,
    input  logic                           cycle_en_i,
    output logic                           irq_evt_valid_o,
    output logic [csr_pkg::XLEN-1:0]       irq_evt_addr_o,
    // accelerator config bus
    output logic [csr_pkg::XLEN-1:0]       mvu_paddr_o,
    output logic [csr_pkg::XLEN-1:0]       mvu_pwdata_o,
    output logic                           mvu_psel_o,
    output logic                           mvu_penable_o,
    output logic                           mvu_pwrite_o
);
    import csr_pkg::*;

    logic            csr_we;
    logic            csr_re;
    logic            mret;
    logic [XLEN-1:0] wdata;
    logic [SEL_W-1:0] sel;
    // register values toward the read mux
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [63:0]     mcycle;

    csr_op_decode u_op_decode (
        .op_i(csr_op_i), .wdata_i(csr_wdata_i), .rdata_i(csr_rdata_o),
        .csr_we_o(csr_we), .csr_re_o(csr_re), .mret_o(mret), .wdata_o(wdata)
    );

    csr_addr_decode u_addr_decode (
        .addr_i(csr_addr_i), .csr_we_i(csr_we), .csr_re_i(csr_re),
        .sel_o(sel), .illegal_o(csr_illegal_o)
    );

    csr_read_mux #(.hart_id(hart_id)) u_read_mux (
        .sel_i(sel), .csr_re_i(csr_re),
        .mstatus_i(mstatus), .mie_i(mie), .mip_i(mip), .mtvec_i(mtvec),
        .mepc_i(mepc), .mcause_i(mcause), .mtval_i(mtval), .mcycle_i(mcycle),
        .rdata_o(csr_rdata_o)
    );

    csr_machine_regs u_machine_regs (
        .clk(clk), .mtvec_rst_load_q(mtvec_rst_load_q), .sel_i(sel), .csr_we_i(csr_we),
        .wdata_i(wdata), .boot_addr_i(boot_addr_i), .irq_i(irq_i),
        .time_irq_i(time_irq_i), .ipi_i(ipi_i), .mvu_irq_i(mvu_irq_i),
        .cycle_en_i(cycle_en_i), .mie_o(mie), .mip_o(mip), .mtvec_o(mtvec),
        .mtval_o(mtval), .mcycle_o(mcycle)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk(clk), .mtvec_rst_load_q(mtvec_rst_load_q), .sel_i(sel), .csr_we_i(csr_we),
        .wdata_i(wdata), .mret_i(mret), .mie_i(mie), .mip_i(mip), .mtvec_i(mtvec),
        .pc_i(pc_i), .cause_i(cause_i), .mstatus_o(mstatus), .mepc_o(mepc),
        .mcause_o(mcause), .irq_evt_valid_o(irq_evt_valid_o),
        .irq_evt_addr_o(irq_evt_addr_o)
    );

    mvu_cfg_port u_mvu_cfg_port (
        .clk(clk), .mtvec_rst_load_q(mtvec_rst_load_q), .sel_i(sel), .csr_we_i(csr_we),
        .addr_i(csr_addr_i), .wdata_i(wdata), .paddr_o(mvu_paddr_o),
        .pwdata_o(mvu_pwdata_o), .psel_o(mvu_psel_o), .penable_o(mvu_penable_o),
        .pwrite_o(mvu_pwrite_o)
    );

endmodule

// File: verilog/csr_machine_regs.sv
`timescale 1ns/100ps
module csr_machine_regs (
    input  logic                      clk,
    input  logic                      mtvec_rst_load_q,
    input  logic [csr_pkg::SEL_W-1:0] sel_i,
    input  logic                      csr_we_i,
    input  logic [csr_pkg::XLEN-1:0]  wdata_i,
    input  logic [csr_pkg::XLEN-1:0]  boot_addr_i,
    input  logic                      irq_i,
    input  logic                      time_irq_i,
    input  logic                      ipi_i,
    input  logic                      mvu_irq_i,
    input  logic                      cycle_en_i,
    output logic [csr_pkg::XLEN-1:0]  mie_o,
    output logic [csr_pkg::XLEN-1:0]  mip_o,
    output logic [csr_pkg::XLEN-1:0]  mtvec_o,
    output logic [csr_pkg::XLEN-1:0]  mtval_o,
    output logic [63:0]               mcycle_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] mip_d;

    always_comb begin
        // software write only reaches the supported bits
        if (csr_we_i && sel_i == SEL_MIP) begin
            mip_d = wdata_i & MIP_MASK;
        end else begin
            mip_d = mip_o;
        end
        // level lines just get sampled
        mip_d[IRQ_M_SOFT]  = ipi_i;
        mip_d[IRQ_M_TIMER] = time_irq_i;
        mip_d[IRQ_M_EXT]   = irq_i;
        // mvu pending is sticky until written
        if (!(csr_we_i && sel_i == SEL_MIP)) begin
            mip_d[IRQ_MVU] = mip_o[IRQ_MVU] | mvu_irq_i;
        end
    end

    always_ff @(posedge clk) begin
        if (mtvec_rst_load_q) begin
            mie_o    <= '0;
            mip_o    <= '0;
            // boot vector comes in while reset is held
            mtvec_o  <= boot_addr_i;
            mtval_o  <= '0;
            mcycle_o <= '0;
        end else begin
            mip_o <= mip_d;
            if (csr_we_i && sel_i == SEL_MIE) begin
                mie_o <= wdata_i & MIP_MASK;
            end
            if (csr_we_i && sel_i == SEL_MTVEC) begin
                mtvec_o <= wdata_i;
            end
            if (csr_we_i && sel_i == SEL_MTVAL) begin
                mtval_o <= wdata_i;
            end
            if (cycle_en_i) begin
                mcycle_o <= mcycle_o + 64'd1;
            end
        end
    end

endmodule

// File: verilog/csr_op_decode.sv
`timescale 1ns/100ps
module csr_op_decode (
    input  logic [csr_pkg::CSR_OP_W-1:0] op_i,
    input  logic [csr_pkg::XLEN-1:0]     wdata_i,
    input  logic [csr_pkg::XLEN-1:0]     rdata_i,
    output logic                         csr_we_o,
    output logic                         csr_re_o,
    output logic                         mret_o,
    output logic [csr_pkg::XLEN-1:0]     wdata_o
);
    import csr_pkg::*;

    always_comb begin
        // idle unless a known op comes in
        csr_we_o = 1'b0;
        csr_re_o = 1'b0;
        mret_o   = 1'b0;
        case (op_i)
            CSR_OP_RW, CSR_OP_SET, CSR_OP_CLEAR: begin
                csr_we_o = 1'b1;
                csr_re_o = 1'b1;
            end
            // return from trap, no csr side effects
            CSR_OP_MRET: mret_o = 1'b1;
            default: ;
        endcase
    end

    // set and clear merge with the current value
    always_comb begin
        case (op_i)
            CSR_OP_SET:   wdata_o = wdata_i | rdata_i;
            CSR_OP_CLEAR: wdata_o = ~wdata_i & rdata_i;
            default:      wdata_o = wdata_i;
        endcase
    end

endmodule

// File: verilog/csr_pkg.sv
package csr_pkg;

    //======================================================================
    // widths
    //======================================================================
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    //======================================================================
    // machine csr addresses
    //======================================================================
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP       = 12'h344;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hF14;
    // accelerator csrs start here and run to the top
    localparam logic [CSR_ADDR_W-1:0] MVU_CSR_BASE  = 12'hF20;

    //======================================================================
    // csr operations
    //======================================================================
    localparam int CSR_OP_W = 3;
    localparam logic [CSR_OP_W-1:0] CSR_OP_NONE  = 3'd0;
    localparam logic [CSR_OP_W-1:0] CSR_OP_RW    = 3'd1;
    localparam logic [CSR_OP_W-1:0] CSR_OP_SET   = 3'd2;
    localparam logic [CSR_OP_W-1:0] CSR_OP_CLEAR = 3'd3;
    localparam logic [CSR_OP_W-1:0] CSR_OP_MRET  = 3'd4;

    // register select codes, one per decoded csr
    localparam int SEL_W = 4;
    localparam logic [SEL_W-1:0] SEL_NONE      = 4'd0;
    localparam logic [SEL_W-1:0] SEL_MSTATUS   = 4'd1;
    localparam logic [SEL_W-1:0] SEL_MISA      = 4'd2;
    localparam logic [SEL_W-1:0] SEL_MIE       = 4'd3;
    localparam logic [SEL_W-1:0] SEL_MTVEC     = 4'd4;
    localparam logic [SEL_W-1:0] SEL_MEPC      = 4'd5;
    localparam logic [SEL_W-1:0] SEL_MCAUSE    = 4'd6;
    localparam logic [SEL_W-1:0] SEL_MTVAL     = 4'd7;
    localparam logic [SEL_W-1:0] SEL_MIP       = 4'd8;
    localparam logic [SEL_W-1:0] SEL_MCYCLE    = 4'd9;
    localparam logic [SEL_W-1:0] SEL_MCYCLEH   = 4'd10;
    localparam logic [SEL_W-1:0] SEL_MVENDORID = 4'd11;
    localparam logic [SEL_W-1:0] SEL_MARCHID   = 4'd12;
    localparam logic [SEL_W-1:0] SEL_MIMPID    = 4'd13;
    localparam logic [SEL_W-1:0] SEL_MHARTID   = 4'd14;
    localparam logic [SEL_W-1:0] SEL_MVU       = 4'd15;

    //======================================================================
    // interrupts and identity
    //======================================================================
    localparam int IRQ_M_SOFT  = 3;
    localparam int IRQ_M_TIMER = 7;
    localparam int IRQ_M_EXT   = 11;
    localparam int IRQ_MVU     = 16;
    localparam logic [XLEN-1:0] MIP_MASK = (32'd1 << IRQ_M_SOFT) | (32'd1 << IRQ_M_TIMER)
                                         | (32'd1 << IRQ_M_EXT) | (32'd1 << IRQ_MVU);

    localparam logic [XLEN-1:0] MARCHID_VAL = 32'h0000_0019;
    // mxl = 1, I and M extensions
    localparam logic [XLEN-1:0] ISA_CODE    = 32'h4000_1100;
    localparam int MCAUSE_IRQ_BIT = 31;

    // mstatus field layout, msb first
    typedef struct packed {
        logic       sd;
        logic [13:0] rsvd_30_17;
        logic [1:0] xs;
        logic [1:0] fs;
        logic [4:0] rsvd_12_8;
        logic       mpie;
        logic [1:0] rsvd_6_5;
        logic       upie;
        logic       mie;
        logic [1:0] rsvd_2_1;
        logic       uie;
    } mstatus_fields_t;

    typedef union packed {
        logic [XLEN-1:0] raw;
        mstatus_fields_t f;
    } mstatus_u;

endpackage

// File: verilog/csr_read_mux.sv
`timescale 1ns/100ps
module csr_read_mux #(
    parameter int unsigned hart_id = 0
) (
    input  logic [csr_pkg::SEL_W-1:0] sel_i,
    input  logic                      csr_re_i,
    input  logic [csr_pkg::XLEN-1:0]  mstatus_i,
    input  logic [csr_pkg::XLEN-1:0]  mie_i,
    input  logic [csr_pkg::XLEN-1:0]  mip_i,
    input  logic [csr_pkg::XLEN-1:0]  mtvec_i,
    input  logic [csr_pkg::XLEN-1:0]  mepc_i,
    input  logic [csr_pkg::XLEN-1:0]  mcause_i,
    input  logic [csr_pkg::XLEN-1:0]  mtval_i,
    input  logic [63:0]               mcycle_i,
    output logic [csr_pkg::XLEN-1:0]  rdata_o
);
    import csr_pkg::*;

    always_comb begin
        rdata_o = '0;
        if (csr_re_i) begin
            case (sel_i)
                SEL_MSTATUS:   rdata_o = mstatus_i;
                SEL_MISA:      rdata_o = ISA_CODE;
                SEL_MIE:       rdata_o = mie_i;
                SEL_MTVEC:     rdata_o = mtvec_i;
                SEL_MEPC:      rdata_o = mepc_i;
                SEL_MCAUSE:    rdata_o = mcause_i;
                SEL_MTVAL:     rdata_o = mtval_i;
                SEL_MIP:       rdata_o = mip_i;
                // counter halves
                SEL_MCYCLE:    rdata_o = mcycle_i[31:0];
                SEL_MCYCLEH:   rdata_o = mcycle_i[63:32];
                SEL_MARCHID:   rdata_o = MARCHID_VAL;
                SEL_MHARTID:   rdata_o = XLEN'(hart_id);
                // vendor, impl and accelerator read zero
                default:       rdata_o = '0;
            endcase
        end
    end

endmodule

// File: verilog/csr_trap_ctrl.sv
`timescale 1ns/100ps
module csr_trap_ctrl (
    input  logic                      clk,
    input  logic                      mtvec_rst_load_q,
    input  logic [csr_pkg::SEL_W-1:0] sel_i,
    input  logic                      csr_we_i,
    input  logic [csr_pkg::XLEN-1:0]  wdata_i,
    input  logic                      mret_i,
    input  logic [csr_pkg::XLEN-1:0]  mie_i,
    input  logic [csr_pkg::XLEN-1:0]  mip_i,
    input  logic [csr_pkg::XLEN-1:0]  mtvec_i,
    input  logic [csr_pkg::XLEN-1:0]  pc_i,
    input  logic [csr_pkg::XLEN-1:0]  cause_i,
    output logic [csr_pkg::XLEN-1:0]  mstatus_o,
    output logic [csr_pkg::XLEN-1:0]  mepc_o,
    output logic [csr_pkg::XLEN-1:0]  mcause_o,
    output logic                      irq_evt_valid_o,
    output logic [csr_pkg::XLEN-1:0]  irq_evt_addr_o
);
    import csr_pkg::*;

    mstatus_u        mstatus_q;
    mstatus_u        mstatus_d;
    logic            trap_en;
    logic [XLEN-1:0] mcause_trap;

    //======================================================================
    // trap entry and return events
    //======================================================================
    // only the mvu line can take a trap
    assign trap_en     = mstatus_q.f.mie & mie_i[IRQ_MVU] & mip_i[IRQ_MVU];
    assign mcause_trap = (XLEN'(1) << MCAUSE_IRQ_BIT) | XLEN'(cause_i[4:0]);

    assign irq_evt_valid_o = trap_en | mret_i;
    // mret jumps back, trap goes to the vector
    assign irq_evt_addr_o  = mret_i ? mepc_o : mtvec_i;
    assign mstatus_o       = mstatus_q.raw;

    always_comb begin
        mstatus_d = mstatus_q;
        if (csr_we_i && sel_i == SEL_MSTATUS) begin
            mstatus_d.raw    = wdata_i;
            // user mode and extension state hardwired low
            mstatus_d.f.uie  = 1'b0;
            mstatus_d.f.upie = 1'b0;
            mstatus_d.f.fs   = 2'b00;
            mstatus_d.f.xs   = 2'b00;
            mstatus_d.f.sd   = 1'b0;
        end
        if (trap_en) begin
            mstatus_d.f.mpie = mstatus_q.f.mie;
            mstatus_d.f.mie  = 1'b0;
        end
        // restore enable on return
        if (mret_i) begin
            mstatus_d.f.mie  = mstatus_q.f.mpie;
            mstatus_d.f.mpie = 1'b1;
        end
    end

    //======================================================================
    // state
    //======================================================================
    always_ff @(posedge clk) begin
        if (mtvec_rst_load_q) begin
            mstatus_q.raw <= '0;
            mepc_o        <= '0;
            mcause_o      <= '0;
        end else begin
            mstatus_q <= mstatus_d;
            if (trap_en) begin
                mepc_o   <= pc_i;
                mcause_o <= mcause_trap;
            end else if (csr_we_i && sel_i == SEL_MEPC) begin
                // halfword aligned return address
                mepc_o <= {wdata_i[XLEN-1:1], 1'b0};
            end
        end
    end

endmodule

// File: verilog/mvu_cfg_port.sv
`timescale 1ns/100ps
module mvu_cfg_port (
    input  logic                           clk,
    input  logic                           mtvec_rst_load_q,
    input  logic [csr_pkg::SEL_W-1:0]      sel_i,
    input  logic                           csr_we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic [csr_pkg::XLEN-1:0]       wdata_i,
    output logic [csr_pkg::XLEN-1:0]       paddr_o,
    output logic [csr_pkg::XLEN-1:0]       pwdata_o,
    output logic                           psel_o,
    output logic                           penable_o,
    output logic                           pwrite_o
);
    import csr_pkg::*;

    logic mvu_we;

    assign mvu_we = csr_we_i & (sel_i == SEL_MVU);

    // strobe lasts one cycle per write
    always_ff @(posedge clk) begin
        if (mtvec_rst_load_q) begin
            psel_o <= 1'b0;
        end else begin
            psel_o <= mvu_we;
        end
    end

    // payload captured with the write
    always_ff @(posedge clk) begin
        if (mvu_we) begin
            paddr_o  <= XLEN'(addr_i);
            pwdata_o <= wdata_i;
        end
    end

    // single phase bus, enable and write follow select
    assign penable_o = psel_o;
    assign pwrite_o  = psel_o;

endmodule
